/* Makefile */
# Verilator build of the discard statistics testbench
VERILATOR  = verilator
TOP        = discard_stats_tb
FILELIST   = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log
COMMON     = --sv --timing --assert --timescale 1ns/100ps -f $(FILELIST) --top-module $(TOP)
LINT_FLAGS = --lint-only
SIM_FLAGS  = --binary -j 0 -Mdir $(OBJ_DIR)
FAIL_MSG   = SOME TESTS FAILED
PASS_MSG   = ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
+incdir+logic
logic/meta_package.sv
logic/stats_package.sv
logic/stats_mem_if.sv
logic/sfifo_discard_info.sv
logic/discard_counter.sv
logic/stats_reader.sv
logic/stats_mem_arbiter.sv
logic/discard_stats_top.sv
tb/tb_clock.sv
tb/discard_stats_sva.sv
tb/discard_stats_tb.sv

/* logic/discard_counter.sv */
// counter engine, takes one record at a time from the FIFO head
// and adds one packet plus its length to the matching stats entry
`default_nettype none

module discard_counter (
	input  wire                            clk,
	input  wire                            reset,

	input  meta_package::discard_info_type head,
	input  wire                            empty,
	output logic                           pop,

	stats_mem_if.client                    mem
);

	stats_package::cnt_state_t state;
	logic                      req_q;
	stats_package::stat_addr_t addr_q;
	stats_package::byte_cnt_t  bytes_q;

	// take the head as soon as the engine is free
	assign pop = (state == stats_package::CNT_IDLE) && !empty;

	// increment only, never clears
	assign mem.req      = req_q;
	assign mem.addr     = addr_q;
	assign mem.clear    = 1'b0;
	assign mem.pkt_inc  = stats_package::pkt_cnt_t'(1);
	assign mem.byte_inc = bytes_q;

	// operands latched at pop, stable until the next pop
	always_ff @(posedge clk) begin
		if (pop) begin
			addr_q  <= {head.port, head.reason};
			bytes_q <= stats_package::byte_cnt_t'(head.len);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stats_package::CNT_IDLE;
			req_q <= 1'b0;
		end else begin
			case (state)
				stats_package::CNT_IDLE: begin
					if (pop) begin
						req_q <= 1'b1;
						state <= stats_package::CNT_WAIT;
					end
				end
				stats_package::CNT_WAIT: begin
					// drop req on the grant pulse, leave on done
					if (mem.gnt)
						req_q <= 1'b0;
					if (mem.done)
						state <= stats_package::CNT_IDLE;
				end
				default: state <= stats_package::CNT_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/discard_defines.svh */
// widths, depths and saturation limits for the discard statistics block
// include wherever a width or a limit is needed
`ifndef DISCARD_DEFINES_SVH
`define DISCARD_DEFINES_SVH

// packet metadata fields
`define DISCARD_PORT_W      2
`define DISCARD_REASON_W    2
`define DISCARD_LEN_W       14

// counter widths, one entry per (port, reason)
`define STATS_PKT_W         16
`define STATS_BYTE_W        24
`define STATS_ADDR_W        (`DISCARD_PORT_W + `DISCARD_REASON_W)
`define STATS_ENTRIES       (1 << `STATS_ADDR_W)

// record FIFO holds 2**nbits records
`define DISCARD_FIFO_NBITS  3

// counters stick at all ones
`define STATS_PKT_MAX       16'hFFFF
`define STATS_BYTE_MAX      24'hFF_FFFF

`endif

/* logic/discard_stats_top.sv */
// discard statistics top level, record input and host read port
// upstream must not write while info_full is high
`default_nettype none

`include "discard_defines.svh"

module discard_stats_top (
	input  wire                              clk,
	input  wire                              reset,

	// discard records from the packet pipeline
	input  wire                              info_wr,
	input  meta_package::port_id_t           info_port,
	input  meta_package::discard_reason_t    info_reason,
	input  meta_package::pkt_len_t           info_len,
	output logic                             info_full,

	// host read
	input  wire                              rd_req,
	input  stats_package::stat_addr_t        rd_addr,
	input  wire                              rd_clear,
	output logic                             rd_valid,
	output stats_package::pkt_cnt_t          rd_pkts,
	output stats_package::byte_cnt_t         rd_bytes
);

	meta_package::discard_info_type info_din;
	meta_package::discard_info_type fifo_head;
	logic                           fifo_empty;
	logic                           fifo_pop;

	stats_mem_if cnt_if ();
	stats_mem_if host_if ();

	// pack the record fields
	assign info_din.port   = info_port;
	assign info_din.reason = info_reason;
	assign info_din.len    = info_len;

	// ========================================================================
	// record path
	// ========================================================================

	sfifo_discard_info #(
		.DEPTH_NBITS (`DISCARD_FIFO_NBITS)
	) u_fifo (
		.clk   (clk),
		.reset (reset),
		.din   (info_din),
		.wr    (info_wr),
		.rd    (fifo_pop),
		.dout  (fifo_head),
		.full  (info_full),
		.empty (fifo_empty),
		.count ()
	);

	discard_counter u_counter (
		.clk   (clk),
		.reset (reset),
		.head  (fifo_head),
		.empty (fifo_empty),
		.pop   (fifo_pop),
		.mem   (cnt_if)
	);

	// ========================================================================
	// host path and shared memory
	// ========================================================================

	stats_reader u_reader (
		.clk      (clk),
		.reset    (reset),
		.rd_req   (rd_req),
		.rd_addr  (rd_addr),
		.rd_clear (rd_clear),
		.rd_valid (rd_valid),
		.rd_pkts  (rd_pkts),
		.rd_bytes (rd_bytes),
		.mem      (host_if)
	);

	stats_mem_arbiter u_arbiter (
		.clk       (clk),
		.reset     (reset),
		.cnt_port  (cnt_if),
		.host_port (host_if)
	);

endmodule

`default_nettype wire

/* logic/meta_package.sv */
// packet metadata types carried by the discard record
// fields come straight from the packet pipeline's drop report
`default_nettype none

`include "discard_defines.svh"

package meta_package;

	// ingress port number
	typedef logic [`DISCARD_PORT_W-1:0] port_id_t;

	// drop cause code
	typedef logic [`DISCARD_REASON_W-1:0] discard_reason_t;

	// packet length in bytes
	typedef logic [`DISCARD_LEN_W-1:0] pkt_len_t;

	// one discard record, 18 bits
	typedef struct packed {
		port_id_t        port;
		discard_reason_t reason;
		pkt_len_t        len;
	} discard_info_type;

endpackage

`default_nettype wire

/* logic/sfifo_discard_info.sv */
// first-word-fall-through FIFO of discard records
// head record always sits on dout while empty is low, rd pops it
`default_nettype none

`include "discard_defines.svh"

module sfifo_discard_info #(
	parameter int DEPTH_NBITS = `DISCARD_FIFO_NBITS
) (
	input  wire                           clk,
	input  wire                           reset,

	input  meta_package::discard_info_type din,
	input  wire                           wr,
	input  wire                           rd,

	output meta_package::discard_info_type dout,
	output logic                          full,
	output logic                          empty,
	output logic [DEPTH_NBITS:0]          count
);

	localparam int DEPTH = 1 << DEPTH_NBITS;

	// ========================================================================
	// storage and pointers
	// ========================================================================

	meta_package::discard_info_type fifod [DEPTH];

	logic [DEPTH_NBITS-1:0] rptr, wptr;
	logic [DEPTH_NBITS-1:0] n_rptr;
	logic [DEPTH_NBITS:0]   n_count;
	logic                   do_wr, do_rd;

	// write while full is dropped, pop while empty ignored
	assign do_wr = wr & ~full;
	assign do_rd = rd & ~empty;

	assign n_rptr = rptr + DEPTH_NBITS'(do_rd);

	always_comb begin
		n_count = count;
		if (do_wr & ~do_rd)
			n_count = count + 1'b1;
		else if (do_rd & ~do_wr)
			n_count = count - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			fifod[wptr] <= din;
	end

	// ========================================================================
	// registered head stage
	// ========================================================================

	// next head is the new write when nothing else is left behind it
	always_ff @(posedge clk) begin
		if (do_wr && (wptr == n_rptr))
			dout <= din;
		else
			dout <= fifod[n_rptr];
	end

	// flags and count all registered
	always_ff @(posedge clk) begin
		if (reset) begin
			rptr  <= '0;
			wptr  <= '0;
			count <= '0;
			full  <= 1'b0;
			empty <= 1'b1;
		end else begin
			rptr  <= n_rptr;
			if (do_wr)
				wptr <= wptr + 1'b1;
			count <= n_count;
			full  <= (n_count == (DEPTH_NBITS+1)'(DEPTH));
			empty <= (n_count == '0);
		end
	end

endmodule

`default_nettype wire

/* logic/stats_mem_arbiter.sv */
// owns the stats RAM, grants the two clients in turn and runs
// each access as read in the grant cycle, write-back the next
`default_nettype none

`include "discard_defines.svh"

module stats_mem_arbiter (
	input  wire           clk,
	input  wire           reset,

	stats_mem_if.arbiter  cnt_port,
	stats_mem_if.arbiter  host_port
);

	stats_package::stat_entry_t ram [`STATS_ENTRIES];

	stats_package::arb_state_t  state;
	logic                       prio_host;
	logic                       sweep_busy;
	stats_package::stat_addr_t  sweep_addr;
	logic                       grant_cnt, grant_host, any_grant;
	stats_package::stat_addr_t  sel_addr;

	// operation latched at grant
	logic                       owner_host;
	stats_package::stat_addr_t  op_addr;
	logic                       op_clear;
	stats_package::pkt_cnt_t    op_pkt_inc;
	stats_package::byte_cnt_t   op_byte_inc;
	stats_package::stat_entry_t old_q, new_entry;
	logic [`STATS_PKT_W:0]      pkt_sum;
	logic [`STATS_BYTE_W:0]     byte_sum;

	// ========================================================================
	// grant, round robin, no grant during the sweep or a write-back
	// ========================================================================

	always_comb begin
		grant_cnt  = 1'b0;
		grant_host = 1'b0;
		if ((state == stats_package::ARB_IDLE) && !sweep_busy) begin
			if (host_port.req && (prio_host || !cnt_port.req))
				grant_host = 1'b1;
			else if (cnt_port.req)
				grant_cnt = 1'b1;
		end
	end

	assign any_grant = grant_cnt | grant_host;
	assign sel_addr  = grant_host ? host_port.addr : cnt_port.addr;

	assign cnt_port.gnt        = grant_cnt;
	assign host_port.gnt       = grant_host;
	assign cnt_port.done       = (state == stats_package::ARB_WRITE) && !owner_host;
	assign host_port.done      = (state == stats_package::ARB_WRITE) && owner_host;
	assign cnt_port.old_entry  = old_q;
	assign host_port.old_entry = old_q;

	// saturating add, each field sticks at all ones
	assign pkt_sum  = {1'b0, old_q.pkts} + {1'b0, op_pkt_inc};
	assign byte_sum = {1'b0, old_q.bytes} + {1'b0, op_byte_inc};

	always_comb begin
		new_entry.pkts  = pkt_sum[`STATS_PKT_W] ? `STATS_PKT_MAX : pkt_sum[`STATS_PKT_W-1:0];
		new_entry.bytes = byte_sum[`STATS_BYTE_W] ? `STATS_BYTE_MAX
		                                          : byte_sum[`STATS_BYTE_W-1:0];
		if (op_clear)
			new_entry = '0;
	end

	// ========================================================================
	// RAM and operand registers
	// ========================================================================

	always_ff @(posedge clk) begin
		if (any_grant) begin
			old_q       <= ram[sel_addr];
			op_addr     <= sel_addr;
			owner_host  <= grant_host;
			op_clear    <= grant_host ? host_port.clear : cnt_port.clear;
			op_pkt_inc  <= grant_host ? host_port.pkt_inc : cnt_port.pkt_inc;
			op_byte_inc <= grant_host ? host_port.byte_inc : cnt_port.byte_inc;
		end
		if (sweep_busy)
			ram[sweep_addr] <= '0;
		else if (state == stats_package::ARB_WRITE)
			ram[op_addr] <= new_entry;
	end

	// control, sweep zeroes one entry per cycle after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= stats_package::ARB_IDLE;
			prio_host  <= 1'b0;
			sweep_busy <= 1'b1;
			sweep_addr <= '0;
		end else begin
			if (sweep_busy) begin
				sweep_addr <= sweep_addr + 1'b1;
				if (sweep_addr == stats_package::stat_addr_t'(`STATS_ENTRIES - 1))
					sweep_busy <= 1'b0;
			end
			case (state)
				stats_package::ARB_IDLE: begin
					if (any_grant) begin
						state     <= stats_package::ARB_WRITE;
						// other client wins the next tie
						prio_host <= grant_cnt;
					end
				end
				default: state <= stats_package::ARB_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/stats_mem_if.sv */
// atomic read-modify-write access from one client to the stats arbiter
// one instance per client
`default_nettype none

interface stats_mem_if;

	// client side, held steady until gnt
	logic                     req;
	stats_package::stat_addr_t addr;
	logic                     clear;
	stats_package::pkt_cnt_t  pkt_inc;
	stats_package::byte_cnt_t byte_inc;

	// arbiter side
	// gnt: one-cycle pulse, RAM read in that cycle
	// done: next cycle, old_entry valid with it
	logic                       gnt;
	logic                       done;
	stats_package::stat_entry_t old_entry;

	modport client (
		output req, addr, clear, pkt_inc, byte_inc,
		input  gnt, done, old_entry
	);

	modport arbiter (
		input  req, addr, clear, pkt_inc, byte_inc,
		output gnt, done, old_entry
	);

endinterface

`default_nettype wire

/* logic/stats_package.sv */
// statistics memory types and the state enums of its clients
// entry index is {port, reason}
`default_nettype none

`include "discard_defines.svh"

package stats_package;

	typedef logic [`STATS_ADDR_W-1:0] stat_addr_t;
	typedef logic [`STATS_PKT_W-1:0]  pkt_cnt_t;
	typedef logic [`STATS_BYTE_W-1:0] byte_cnt_t;

	// one counter entry, 40 bits
	typedef struct packed {
		pkt_cnt_t  pkts;
		byte_cnt_t bytes;
	} stat_entry_t;

	// arbiter FSM, grant cycle is the read, WRITE is the write-back
	typedef enum logic {ARB_IDLE, ARB_WRITE} arb_state_t;

	// counter engine FSM
	typedef enum logic {CNT_IDLE, CNT_WAIT} cnt_state_t;

endpackage

`default_nettype wire

/* logic/stats_reader.sv */
// host read port, one outstanding read at a time
// a read is a zero increment, optionally clearing the entry
`default_nettype none

module stats_reader (
	input  wire                        clk,
	input  wire                        reset,

	input  wire                        rd_req,
	input  stats_package::stat_addr_t  rd_addr,
	input  wire                        rd_clear,

	output logic                       rd_valid,
	output stats_package::pkt_cnt_t    rd_pkts,
	output stats_package::byte_cnt_t   rd_bytes,

	stats_mem_if.client                mem
);

	logic                      pending;
	logic                      req_q;
	logic                      accept;
	stats_package::stat_addr_t addr_q;
	logic                      clear_q;

	// new strobes ignored while one is in flight
	assign accept = rd_req & ~pending;

	assign mem.req      = req_q;
	assign mem.addr     = addr_q;
	assign mem.clear    = clear_q;
	assign mem.pkt_inc  = '0;
	assign mem.byte_inc = '0;

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q  <= rd_addr;
			clear_q <= rd_clear;
		end
		// old_entry is the value before any clear
		if (mem.done) begin
			rd_pkts  <= mem.old_entry.pkts;
			rd_bytes <= mem.old_entry.bytes;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending  <= 1'b0;
			req_q    <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= mem.done;
			if (accept) begin
				pending <= 1'b1;
				req_q   <= 1'b1;
			end
			if (mem.gnt)
				req_q <= 1'b0;
			if (mem.done)
				pending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* tb/discard_stats_sva.sv */
// assertions bound into the record FIFO and the stats arbiter
// each bind ties the signals of the other block to zero
`default_nettype none

`include "discard_defines.svh"

module discard_stats_sva #(
	parameter int COUNT_W = `DISCARD_FIFO_NBITS + 1,
	parameter int DEPTH   = 1 << `DISCARD_FIFO_NBITS
) (
	input wire               clk,
	input wire               reset,
	// FIFO side
	input wire               wr,
	input wire               rd,
	input wire               full,
	input wire               empty,
	input wire [COUNT_W-1:0] count,
	// arbiter side
	input wire               cnt_gnt,
	input wire               host_gnt,
	input wire               cnt_done,
	input wire               host_done
);

	timeunit 1ns;
	timeprecision 100ps;

	// upstream honours info_full
	no_write_when_full: assert property (@(posedge clk) disable iff (reset) !(wr && full))
		else $error("record written while the FIFO is full");

	// counter engine only pops a present head
	no_pop_when_empty: assert property (@(posedge clk) disable iff (reset) !(rd && empty))
		else $error("record popped while the FIFO is empty");

	one_grant_at_a_time: assert property (@(posedge clk) disable iff (reset)
		!(cnt_gnt && host_gnt))
		else $error("both clients granted in the same cycle");

	// write-back cycle right after the grant, never later
	cnt_done_after_gnt: assert property (@(posedge clk) disable iff (reset)
		cnt_done == $past(cnt_gnt))
		else $error("counter client done does not follow its grant by one cycle");

	host_done_after_gnt: assert property (@(posedge clk) disable iff (reset)
		host_done == $past(host_gnt))
		else $error("host client done does not follow its grant by one cycle");

	count_in_range: assert property (@(posedge clk) disable iff (reset)
		count <= COUNT_W'(DEPTH))
		else $error("FIFO count above its depth");

endmodule

bind sfifo_discard_info discard_stats_sva fifo_checks (
	.clk       (clk),
	.reset     (reset),
	.wr        (wr),
	.rd        (rd),
	.full      (full),
	.empty     (empty),
	.count     (count),
	.cnt_gnt   (1'b0),
	.host_gnt  (1'b0),
	.cnt_done  (1'b0),
	.host_done (1'b0)
);

bind stats_mem_arbiter discard_stats_sva arbiter_checks (
	.clk       (clk),
	.reset     (reset),
	.wr        (1'b0),
	.rd        (1'b0),
	.full      (1'b0),
	.empty     (1'b0),
	.count     ('0),
	.cnt_gnt   (cnt_port.gnt),
	.host_gnt  (host_port.gnt),
	.cnt_done  (cnt_port.done),
	.host_done (host_port.done)
);

`default_nettype wire

/* tb/discard_stats_tb.sv */
// testbench for the discard statistics block
// steps come from a table, expected counters from a saturating model
`default_nettype none

`include "discard_defines.svh"

module discard_stats_tb;

	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [2:0] {
		OP_SCAN, OP_EVENT, OP_READ, OP_READ_CLEAR, OP_BURST, OP_SATURATE, OP_INTERLEAVE
	} op_t;

	// len of zero means a random length
	// exp_pkts is the packet count, or the number of records for the multi-record ops
	typedef struct packed {
		op_t                           op;
		meta_package::port_id_t        port;
		meta_package::discard_reason_t reason;
		meta_package::pkt_len_t        len;
		stats_package::pkt_cnt_t       exp_pkts;
	} step_t;

	localparam int NSTEPS = 20;
	localparam int RD_TIMEOUT = 8;
	localparam int DRAIN_TIMEOUT = 64;
	// 16 cycles a row, plus the 1100 saturation records at up to 6 cycles each
	localparam int WATCHDOG_CYCLES = NSTEPS * 16 + 1100 * 6 + 1000;
	localparam stats_package::pkt_cnt_t  PKT_ALL_ONES  = '1;
	localparam stats_package::byte_cnt_t BYTE_ALL_ONES = '1;

	localparam step_t STEPS [NSTEPS] = '{
		'{OP_SCAN,       2'd0, 2'd0, 14'd0,     16'd0},
		'{OP_EVENT,      2'd0, 2'd1, 14'd100,   16'd0},
		'{OP_EVENT,      2'd0, 2'd1, 14'd200,   16'd0},
		'{OP_EVENT,      2'd2, 2'd3, 14'd0,     16'd0},
		'{OP_EVENT,      2'd0, 2'd1, 14'd0,     16'd0},
		'{OP_EVENT,      2'd3, 2'd0, 14'd1500,  16'd0},
		'{OP_READ,       2'd0, 2'd1, 14'd0,     16'd3},
		'{OP_READ,       2'd2, 2'd3, 14'd0,     16'd1},
		'{OP_READ,       2'd3, 2'd0, 14'd0,     16'd1},
		'{OP_BURST,      2'd1, 2'd2, 14'd0,     16'd24},
		'{OP_READ,       2'd1, 2'd2, 14'd0,     16'd24},
		'{OP_READ,       2'd0, 2'd1, 14'd0,     16'd3},
		'{OP_READ,       2'd0, 2'd1, 14'd0,     16'd3},
		'{OP_READ_CLEAR, 2'd0, 2'd1, 14'd0,     16'd3},
		'{OP_READ,       2'd0, 2'd1, 14'd0,     16'd0},
		'{OP_SATURATE,   2'd3, 2'd3, 14'd16383, 16'd1100},
		'{OP_READ,       2'd3, 2'd3, 14'd0,     16'd1100},
		'{OP_INTERLEAVE, 2'd2, 2'd0, 14'd0,     16'd40},
		'{OP_READ,       2'd2, 2'd0, 14'd0,     16'd0},
		'{OP_READ,       2'd2, 2'd3, 14'd0,     16'd1}
	};

	logic                          clk;
	logic                          reset;
	logic                          info_wr;
	meta_package::port_id_t        info_port;
	meta_package::discard_reason_t info_reason;
	meta_package::pkt_len_t        info_len;
	logic                          info_full;
	logic                          rd_req;
	stats_package::stat_addr_t     rd_addr;
	logic                          rd_clear;
	logic                          rd_valid;
	stats_package::pkt_cnt_t       rd_pkts;
	stats_package::byte_cnt_t      rd_bytes;

	// reference counters, one per (port, reason)
	stats_package::stat_entry_t model [`STATS_ENTRIES];
	logic [31:0]                lfsr;
	logic                       seen_full;
	logic                       pushes_done;
	int                         errors;

	tb_clock u_clock (
		.clk (clk)
	);

	discard_stats_top dut (
		.clk         (clk),
		.reset       (reset),
		.info_wr     (info_wr),
		.info_port   (info_port),
		.info_reason (info_reason),
		.info_len    (info_len),
		.info_full   (info_full),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.rd_clear    (rd_clear),
		.rd_valid    (rd_valid),
		.rd_pkts     (rd_pkts),
		.rd_bytes    (rd_bytes)
	);

	// ========================================================================
	// failure reporting and compare tasks
	// ========================================================================

	task automatic stop_on_failure();
		errors++;
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_pkts(input stats_package::pkt_cnt_t got,
			input stats_package::pkt_cnt_t exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s, packets %0d, expected %0d", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_bytes(input stats_package::byte_cnt_t got,
			input stats_package::byte_cnt_t exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s, bytes %0d, expected %0d", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	// ========================================================================
	// random lengths and the reference model
	// ========================================================================

	// galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per length bit
	function automatic meta_package::pkt_len_t random_len();
		meta_package::pkt_len_t v;
		v = '0;
		for (int i = 0; i < `DISCARD_LEN_W; i++) begin
			lfsr = lfsr_next(lfsr);
			v[i] = lfsr[0];
		end
		return v;
	endfunction

	function automatic meta_package::pkt_len_t pick_len(input meta_package::pkt_len_t len);
		return (len == '0) ? random_len() : len;
	endfunction

	// both fields stop at all ones once the headroom is used up
	function automatic void model_add(input stats_package::stat_addr_t a,
			input meta_package::pkt_len_t len);
		stats_package::byte_cnt_t room;
		room = BYTE_ALL_ONES - model[a].bytes;
		if (model[a].pkts != PKT_ALL_ONES)
			model[a].pkts = model[a].pkts + stats_package::pkt_cnt_t'(1);
		if (room < stats_package::byte_cnt_t'(len))
			model[a].bytes = BYTE_ALL_ONES;
		else
			model[a].bytes = model[a].bytes + stats_package::byte_cnt_t'(len);
	endfunction

	// ========================================================================
	// drivers, all called and returning on a falling edge
	// ========================================================================

	// held off while info_full, back to back otherwise
	task automatic push_record(input meta_package::port_id_t port,
			input meta_package::discard_reason_t reason, input meta_package::pkt_len_t len);
		while (info_full) begin
			seen_full = 1'b1;
			@(negedge clk);
		end
		info_wr     = 1'b1;
		info_port   = port;
		info_reason = reason;
		info_len    = len;
		model_add(stats_package::stat_addr_t'({port, reason}), len);
		@(negedge clk);
		info_wr = 1'b0;
	endtask

	// FIFO empty and counter engine idle means every record is in the RAM
	task automatic wait_drain();
		int n;
		n = 0;
		while (!(dut.fifo_empty && dut.u_counter.state == stats_package::CNT_IDLE)) begin
			if (n == DRAIN_TIMEOUT) begin
				$display("records still pending after %0d cycles of draining", DRAIN_TIMEOUT);
				stop_on_failure();
			end
			n++;
			@(negedge clk);
		end
	endtask

	// rd_valid pulse ends every read, latency varies
	task automatic wait_read_result(input stats_package::stat_addr_t addr,
			output stats_package::pkt_cnt_t pkts, output stats_package::byte_cnt_t bytes);
		int n;
		n = 0;
		while (!rd_valid) begin
			if (n == RD_TIMEOUT) begin
				$display("read of entry %0d got no rd_valid within %0d cycles", addr, RD_TIMEOUT);
				stop_on_failure();
			end
			n++;
			@(negedge clk);
		end
		pkts  = rd_pkts;
		bytes = rd_bytes;
	endtask

	task automatic host_read(input stats_package::stat_addr_t addr, input logic clear,
			output stats_package::pkt_cnt_t pkts, output stats_package::byte_cnt_t bytes);
		rd_req   = 1'b1;
		rd_addr  = addr;
		rd_clear = clear;
		@(negedge clk);
		rd_req = 1'b0;
		wait_read_result(addr, pkts, bytes);
	endtask

	// packets against the table, bytes against the model
	task automatic check_read(input stats_package::stat_addr_t a, input logic clear,
			input stats_package::pkt_cnt_t exp_pkts, input string what);
		stats_package::pkt_cnt_t  p;
		stats_package::byte_cnt_t b;
		host_read(a, clear, p, b);
		check_pkts(p, exp_pkts, what);
		check_bytes(b, model[a].bytes, what);
		if (clear)
			model[a] = '0;
	endtask

	// clear reads race the traffic, nothing may be lost between them
	task automatic run_interleave(input step_t s);
		stats_package::stat_addr_t a;
		stats_package::pkt_cnt_t   p;
		stats_package::pkt_cnt_t   pkt_sum;
		stats_package::byte_cnt_t  b;
		stats_package::byte_cnt_t  byte_sum;
		a = {s.port, s.reason};
		pkt_sum = '0;
		byte_sum = '0;
		pushes_done = 1'b0;
		fork
			begin
				for (int i = 0; i < int'(s.exp_pkts); i++)
					push_record(s.port, s.reason, pick_len(s.len));
				pushes_done = 1'b1;
			end
			begin
				while (!pushes_done) begin
					host_read(a, 1'b1, p, b);
					pkt_sum  = pkt_sum + p;
					byte_sum = byte_sum + b;
					repeat (5) @(negedge clk);
				end
			end
		join
		wait_drain();
		host_read(a, 1'b1, p, b);
		check_pkts(pkt_sum + p, s.exp_pkts, "interleaved clear reads");
		check_bytes(byte_sum + b, model[a].bytes, "interleaved clear reads");
		model[a] = '0;
	endtask

	task automatic run_step(input step_t s);
		stats_package::stat_addr_t a;
		a = {s.port, s.reason};
		case (s.op)
			OP_SCAN: begin
				for (int i = 0; i < `STATS_ENTRIES; i++)
					check_read(stats_package::stat_addr_t'(i), 1'b0, s.exp_pkts, "scan");
			end
			OP_EVENT: push_record(s.port, s.reason, pick_len(s.len));
			OP_READ: begin
				wait_drain();
				check_read(a, 1'b0, s.exp_pkts, "read");
			end
			OP_READ_CLEAR: begin
				wait_drain();
				check_read(a, 1'b1, s.exp_pkts, "read with clear");
			end
			OP_BURST: begin
				seen_full = 1'b0;
				for (int i = 0; i < int'(s.exp_pkts); i++)
					push_record(s.port, s.reason, pick_len(s.len));
				check_flag(seen_full, 1'b1, "info_full seen during burst");
			end
			OP_SATURATE: begin
				for (int i = 0; i < int'(s.exp_pkts); i++)
					push_record(s.port, s.reason, s.len);
			end
			default: run_interleave(s);
		endcase
	endtask

	// ========================================================================
	// main sequence and watchdog
	// ========================================================================

	initial begin
		stats_package::pkt_cnt_t  sweep_pkts;
		stats_package::byte_cnt_t sweep_bytes;
		reset       = 1'b1;
		info_wr     = 1'b0;
		info_port   = '0;
		info_reason = '0;
		info_len    = '0;
		rd_req      = 1'b0;
		rd_addr     = '0;
		rd_clear    = 1'b0;
		lfsr        = 32'h16533a41;
		seen_full   = 1'b0;
		pushes_done = 1'b0;
		errors      = 0;
		for (int i = 0; i < `STATS_ENTRIES; i++)
			model[i] = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		check_flag(info_full, 1'b0, "info_full after reset");
		check_flag(rd_valid, 1'b0, "rd_valid after reset");
		// read strobed at once, held off by the RAM clear sweep
		rd_req = 1'b1;
		@(negedge clk);
		rd_req = 1'b0;
		repeat (16) begin
			check_flag(rd_valid, 1'b0, "rd_valid during clear sweep");
			@(negedge clk);
		end
		wait_read_result(rd_addr, sweep_pkts, sweep_bytes);
		check_pkts(sweep_pkts, '0, "read held over the clear sweep");
		check_bytes(sweep_bytes, '0, "read held over the clear sweep");
		for (int i = 0; i < NSTEPS; i++)
			run_step(STEPS[i]);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$fatal(1, "run ended with errors");
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		stop_on_failure();
	end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
// free running clock for the testbench, 8 ns period
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD_NS = 4
) (
	output logic clk
);

	timeunit 1ns;
	timeprecision 100ps;

	initial clk = 1'b0;

	// first rising edge at 4 ns
	always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

`default_nettype wire
